// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int REG_ADDR_W = 5;

    // ----------------------------------------------------------------------
    // Major opcodes handled by the decoder
    // ----------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        BR_BEQ = 3'b000,
        BR_BNE = 3'b001
    } branch_funct_t;

    // ----------------------------------------------------------------------
    // Operations understood by the ALU
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_control_t;

endpackage

// File: design/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int XLEN = 32;

    // Operand source picked by the hazard unit for each execute operand
    typedef enum logic [1:0] {
        FWD_REG = 2'b00, // Value read from the register file in decode
        FWD_WB  = 2'b01, // Result sitting in the writeback stage
        FWD_MEM = 2'b10  // ALU result sitting in the memory stage
    } forward_sel_t;

endpackage

// File: design/alu.sv
module alu import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic [XLEN-1:0] src_a_i,
    input  logic [XLEN-1:0] src_b_i,
    input  alu_control_t    control_i,
    output logic [XLEN-1:0] result_o,
    output logic            zero_o
);
    logic [4:0] shamt;

    assign shamt = src_b_i[4:0]; // Only the low five bits shift

    always_comb begin
        case (control_i)
            ALU_ADD:  result_o = src_a_i + src_b_i;
            ALU_SUB:  result_o = src_a_i - src_b_i;
            ALU_AND:  result_o = src_a_i & src_b_i;
            ALU_OR:   result_o = src_a_i | src_b_i;
            ALU_XOR:  result_o = src_a_i ^ src_b_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(src_a_i) < $signed(src_b_i)};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, src_a_i < src_b_i};
            ALU_SLL:  result_o = src_a_i << shamt;
            ALU_SRL:  result_o = src_a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(src_a_i) >>> shamt);
            default:  result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

// File: design/register_file.sv
module register_file import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    output logic [XLEN-1:0]       rd1_o,
    output logic [XLEN-1:0]       rd2_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       wd_i
);
    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // A write landing this cycle is seen by a read of the same register
    assign rd1_o = (rs1_i == '0) ? '0 : (we_i && rd_i == rs1_i) ? wd_i : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : (we_i && rd_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

// File: design/decode_stage.sv
module decode_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  flush_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       rd1_o,
    output logic [XLEN-1:0]       rd2_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       pc_plus_4_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_ext_o,
    output alu_control_t          alu_control_o,
    output logic                  alu_src_o,
    output logic                  is_branch_o,
    output logic                  branch_ne_o,
    output logic                  reg_write_o,
    output logic                  valid_o
);
    logic [31:0]     instr_q;
    logic [XLEN-1:0] pc_q;
    logic            valid_q;
    logic [2:0]      funct3;
    logic            known_op;

    function automatic alu_control_t alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            {instr_q, pc_q, valid_q} <= '0;
        end else begin
            {instr_q, pc_q, valid_q} <= {instr_i, pc_i, instr_valid_i};
        end
    end

    register_file u_register_file (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rs1_i   (rs1_o),
        .rs2_i   (rs2_o),
        .rd1_o   (rd1_o),
        .rd2_o   (rd2_o),
        .we_i    (wb_we_i),
        .rd_i    (wb_rd_i),
        .wd_i    (wb_data_i)
    );

    assign funct3      = instr_q[14:12];
    assign rs1_o       = instr_q[19:15];
    assign rs2_o       = instr_q[24:20];
    assign rd_o        = instr_q[11:7];
    assign pc_o        = pc_q;
    assign pc_plus_4_o = pc_q + 32'd4;
    assign branch_ne_o = (funct3 == BR_BNE);

    always_comb begin
        alu_control_o = ALU_ADD;
        alu_src_o     = 1'b0;
        is_branch_o   = 1'b0;
        known_op      = 1'b1;
        imm_ext_o     = {{20{instr_q[31]}}, instr_q[31:20]};
        case (opcode_t'(instr_q[6:0]))
            OPC_OP: alu_control_o = alu_op(funct3, instr_q[30]);
            OPC_OP_IMM: begin
                alu_src_o     = 1'b1;
                alu_control_o = alu_op(funct3, instr_q[30] && funct3 == 3'b101); // ADDI has no SUB
            end
            OPC_BRANCH: begin
                is_branch_o   = 1'b1;
                alu_control_o = ALU_SUB; // Equality shows up as a zero result
                imm_ext_o     = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                                 instr_q[30:25], instr_q[11:8], 1'b0};
                known_op      = (funct3 == BR_BEQ) || (funct3 == BR_BNE);
            end
            default: known_op = 1'b0;
        endcase
    end

    assign valid_o     = valid_q && known_op; // Unknown encodings travel on as bubbles
    assign reg_write_o = valid_o && !is_branch_o && (rd_o != '0);

endmodule

// File: design/execute_stage.sv
module execute_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       rd1_i,
    input  logic [XLEN-1:0]       rd2_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       pc_plus_4_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       imm_ext_i,
    input  alu_control_t          alu_control_i,
    input  logic                  alu_src_i,
    input  logic                  is_branch_i,
    input  logic                  branch_ne_i,
    input  logic                  reg_write_i,
    input  logic                  valid_i,
    input  logic [XLEN-1:0]       alu_result_m_i,
    input  logic [XLEN-1:0]       result_w_i,
    input  logic                  flush_i,
    input  forward_sel_t          forward_a_i,
    input  forward_sel_t          forward_b_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  branch_taken_o,
    output logic [XLEN-1:0]       branch_target_o,
    output logic [XLEN-1:0]       alu_result_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  reg_write_o,
    output logic                  valid_o
);
    logic [XLEN-1:0]       rd1_e, rd2_e, pc_e, pc_plus_4_e, imm_ext_e;
    logic [REG_ADDR_W-1:0] rs1_e, rs2_e, rd_e;
    alu_control_t          alu_control_e;
    logic                  alu_src_e, is_branch_e, branch_ne_e, reg_write_e, valid_e;
    logic [XLEN-1:0]       src_a, fwd_b, src_b;
    logic                  zero;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            {rd1_e, rd2_e, pc_e, pc_plus_4_e, imm_ext_e} <= '0;
            {rs1_e, rs2_e, rd_e} <= '0;
            alu_control_e <= ALU_ADD;
            {alu_src_e, is_branch_e, branch_ne_e, reg_write_e, valid_e} <= '0;
        end else begin
            {rd1_e, rd2_e, pc_e, pc_plus_4_e, imm_ext_e} <=
                {rd1_i, rd2_i, pc_i, pc_plus_4_i, imm_ext_i};
            {rs1_e, rs2_e, rd_e} <= {rs1_i, rs2_i, rd_i};
            alu_control_e <= alu_control_i;
            {alu_src_e, is_branch_e, branch_ne_e, reg_write_e, valid_e} <=
                {alu_src_i, is_branch_i, branch_ne_i, reg_write_i, valid_i};
        end
    end

    // ----------------------------------------------------------------------
    // Operand forwarding
    // ----------------------------------------------------------------------
    always_comb begin
        case (forward_a_i)
            FWD_REG: src_a = rd1_e;
            FWD_WB:  src_a = result_w_i;
            FWD_MEM: src_a = alu_result_m_i;
            default: src_a = '0;
        endcase
    end

    always_comb begin
        case (forward_b_i)
            FWD_REG: fwd_b = rd2_e;
            FWD_WB:  fwd_b = result_w_i;
            FWD_MEM: fwd_b = alu_result_m_i;
            default: fwd_b = '0;
        endcase
    end

    assign src_b = alu_src_e ? imm_ext_e : fwd_b;

    alu u_alu (
        .src_a_i   (src_a),
        .src_b_i   (src_b),
        .control_i (alu_control_e),
        .result_o  (alu_result_o),
        .zero_o    (zero)
    );

    // BEQ wants a zero difference and BNE a nonzero one
    assign branch_taken_o  = valid_e && is_branch_e && (zero == !branch_ne_e);
    assign branch_target_o = branch_taken_o ? pc_e + imm_ext_e : pc_plus_4_e; // Next pc

    assign rs1_o       = rs1_e;
    assign rs2_o       = rs2_e;
    assign rd_o        = rd_e;
    assign reg_write_o = reg_write_e;
    assign valid_o     = valid_e;

endmodule

// File: design/retire_stages.sv
module retire_stages import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       alu_result_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  reg_write_i,
    input  logic                  valid_i,
    output logic [XLEN-1:0]       alu_result_m_o,
    output logic [REG_ADDR_W-1:0] rd_m_o,
    output logic                  reg_write_m_o,
    output logic [REG_ADDR_W-1:0] rd_w_o,
    output logic                  reg_write_w_o,
    output logic [XLEN-1:0]       result_w_o
);
    // Memory stage. With no loads or stores it only carries the result
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {alu_result_m_o, rd_m_o, reg_write_m_o} <= '0;
        end else begin
            {alu_result_m_o, rd_m_o} <= {alu_result_i, rd_i};
            reg_write_m_o <= reg_write_i && valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {result_w_o, rd_w_o, reg_write_w_o} <= '0;
        end else begin
            {result_w_o, rd_w_o, reg_write_w_o} <= {alu_result_m_o, rd_m_o, reg_write_m_o};
        end
    end

endmodule

// File: design/hazard_unit.sv
module hazard_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_e_i,
    input  logic [REG_ADDR_W-1:0] rs2_e_i,
    input  logic [REG_ADDR_W-1:0] rd_m_i,
    input  logic                  reg_write_m_i,
    input  logic [REG_ADDR_W-1:0] rd_w_i,
    input  logic                  reg_write_w_i,
    input  logic                  branch_taken_i,
    output forward_sel_t          forward_a_o,
    output forward_sel_t          forward_b_o,
    output logic                  flush_o
);
    // The younger producer wins when both later stages write the register
    function automatic forward_sel_t pick(input logic [REG_ADDR_W-1:0] rs, rd_m, rd_w,
                                          input logic we_m, we_w);
        if (we_m && rd_m != '0 && rd_m == rs) begin
            return FWD_MEM;
        end else if (we_w && rd_w != '0 && rd_w == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign forward_a_o = pick(rs1_e_i, rd_m_i, rd_w_i, reg_write_m_i, reg_write_w_i);
    assign forward_b_o = pick(rs2_e_i, rd_m_i, rd_w_i, reg_write_m_i, reg_write_w_i);
    assign flush_o     = branch_taken_i; // Kills the decode and execute registers

endmodule

// File: design/alu_core.sv
module alu_core import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  retire_valid_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_data_o,
    output logic                  branch_taken_o,
    output logic [XLEN-1:0]       branch_target_o
);
    logic [XLEN-1:0]       rd1_d, rd2_d, pc_d, pc_plus_4_d, imm_ext_d;
    logic [REG_ADDR_W-1:0] rs1_d, rs2_d, rd_d;
    alu_control_t          alu_control_d;
    logic                  alu_src_d, is_branch_d, branch_ne_d, reg_write_d, valid_d;
    logic [REG_ADDR_W-1:0] rs1_e, rs2_e, rd_e;
    logic [XLEN-1:0]       alu_result_e;
    logic                  reg_write_e, valid_e;
    logic [XLEN-1:0]       alu_result_m, result_w;
    logic [REG_ADDR_W-1:0] rd_m, rd_w;
    logic                  reg_write_m, reg_write_w;
    forward_sel_t          forward_a, forward_b;
    logic                  flush;

    decode_stage u_decode_stage (
        .clk_i (clk_i), .reset_i (reset_i),
        .instr_valid_i (instr_valid_i), .instr_i (instr_i), .pc_i (pc_i),
        .flush_i (flush),
        .wb_we_i (reg_write_w), .wb_rd_i (rd_w), .wb_data_i (result_w),
        .rd1_o (rd1_d), .rd2_o (rd2_d), .pc_o (pc_d), .pc_plus_4_o (pc_plus_4_d),
        .rs1_o (rs1_d), .rs2_o (rs2_d), .rd_o (rd_d), .imm_ext_o (imm_ext_d),
        .alu_control_o (alu_control_d), .alu_src_o (alu_src_d),
        .is_branch_o (is_branch_d), .branch_ne_o (branch_ne_d),
        .reg_write_o (reg_write_d), .valid_o (valid_d)
    );

    execute_stage u_execute_stage (
        .clk_i (clk_i), .reset_i (reset_i),
        .rd1_i (rd1_d), .rd2_i (rd2_d), .pc_i (pc_d), .pc_plus_4_i (pc_plus_4_d),
        .rs1_i (rs1_d), .rs2_i (rs2_d), .rd_i (rd_d), .imm_ext_i (imm_ext_d),
        .alu_control_i (alu_control_d), .alu_src_i (alu_src_d),
        .is_branch_i (is_branch_d), .branch_ne_i (branch_ne_d),
        .reg_write_i (reg_write_d), .valid_i (valid_d),
        .alu_result_m_i (alu_result_m), .result_w_i (result_w), .flush_i (flush),
        .forward_a_i (forward_a), .forward_b_i (forward_b),
        .rs1_o (rs1_e), .rs2_o (rs2_e),
        .branch_taken_o (branch_taken_o), .branch_target_o (branch_target_o),
        .alu_result_o (alu_result_e), .rd_o (rd_e),
        .reg_write_o (reg_write_e), .valid_o (valid_e)
    );

    retire_stages u_retire_stages (
        .clk_i (clk_i), .reset_i (reset_i),
        .alu_result_i (alu_result_e), .rd_i (rd_e),
        .reg_write_i (reg_write_e), .valid_i (valid_e),
        .alu_result_m_o (alu_result_m), .rd_m_o (rd_m), .reg_write_m_o (reg_write_m),
        .rd_w_o (rd_w), .reg_write_w_o (reg_write_w), .result_w_o (result_w)
    );

    hazard_unit u_hazard_unit (
        .rs1_e_i (rs1_e), .rs2_e_i (rs2_e),
        .rd_m_i (rd_m), .reg_write_m_i (reg_write_m),
        .rd_w_i (rd_w), .reg_write_w_i (reg_write_w),
        .branch_taken_i (branch_taken_o),
        .forward_a_o (forward_a), .forward_b_o (forward_b), .flush_o (flush)
    );

    assign retire_valid_o = reg_write_w; // Only real register writes retire
    assign retire_rd_o    = rd_w;
    assign retire_data_o  = result_w;

endmodule

// File: testbench/hazard_unit_properties.sv
module hazard_unit_properties import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic [REG_ADDR_W-1:0] rd_m_i,
    input logic                  reg_write_w_i,
    input logic                  branch_taken_i,
    input forward_sel_t          forward_a_i,
    input forward_sel_t          forward_b_i,
    input logic                  flush_i,
    input logic                  valid_d_i,
    input logic                  valid_e_i
);
    int unsigned fail_count = 0; // Read by the testbench for its verdict

    // ----------------------------------------------------------------------
    // Forwarding selects
    // ----------------------------------------------------------------------
    no_mem_from_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_m_i == '0 |-> forward_a_i != FWD_MEM && forward_b_i != FWD_MEM)
    else begin
        fail_count++;
        $error("Memory-stage forwarding selected while the memory stage targets x0");
    end

    no_wb_without_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !reg_write_w_i |-> forward_a_i != FWD_WB && forward_b_i != FWD_WB)
    else begin
        fail_count++;
        $error("Writeback forwarding selected while the writeback stage writes nothing");
    end

    // A taken branch leaves no valid instruction in decode or execute behind it
    flush_annuls_younger: assert property (@(posedge clk_i) disable iff (reset_i)
        branch_taken_i |-> flush_i ##1 (!valid_d_i && !valid_e_i))
    else begin
        fail_count++;
        $error("Taken branch did not flush the decode and execute stages");
    end

endmodule

// File: testbench/alu_core_tb.sv
module alu_core_tb import rv_isa_pkg::*, pipe_ctrl_pkg::*; ();
    logic                  clk_i, reset_i, instr_valid_i;
    logic [31:0]           instr_i;
    logic [XLEN-1:0]       pc_i;
    logic                  retire_valid_o, branch_taken_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_data_o, branch_target_o;

    logic [XLEN-1:0]       model_regs [0:31];
    int                    cycle, errors, checks, mark_checks, mark_errors, skip;
    integer                seed;
    int                    ret_due[$], br_due[$];
    logic [REG_ADDR_W-1:0] ret_rd[$];
    logic [XLEN-1:0]       ret_data[$], br_target[$];

    alu_core u_alu_core (.*);

    bind alu_core hazard_unit_properties u_hazard_unit_properties (
        .clk_i (clk_i), .reset_i (reset_i), .rd_m_i (rd_m), .reg_write_w_i (reg_write_w),
        .branch_taken_i (branch_taken_o), .forward_a_i (forward_a),
        .forward_b_i (forward_b), .flush_i (flush),
        .valid_d_i (valid_d), .valid_e_i (valid_e)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------------------------------------
    // Instruction encoders and the reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] enc_op(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [2:0] f3, input logic [11:0] imm,
                                            input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_br(input logic ne, input logic [12:0] off,
                                           input logic [4:0] rs1, rs2);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic void exec_ref(input logic [31:0] ins, input logic [XLEN-1:0] pc,
                                     output logic wr, output logic [XLEN-1:0] res,
                                     output logic taken, output logic [XLEN-1:0] target);
        logic [XLEN-1:0] a, b;
        logic [2:0]      f3;
        logic            alt;
        f3     = ins[14:12];
        a      = model_regs[ins[19:15]];
        b      = (ins[6:0] == OPC_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        alt    = ins[30] && (ins[6:0] == OPC_OP || f3 == 3'b101); // ADDI never subtracts
        wr     = (ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM) && ins[11:7] != 5'd0;
        target = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        taken  = (ins[6:0] == OPC_BRANCH) && ((model_regs[ins[24:20]] == a) ^ f3[0]);
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (wr) begin
            model_regs[ins[11:7]] = res;
        end
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    task automatic drive_slot(input logic valid, input logic [31:0] ins);
        logic            wr, taken;
        logic [XLEN-1:0] res, target;
        @(posedge clk_i);
        #1;
        instr_valid_i = valid;
        instr_i       = ins;
        pc_i          = pc_i + 32'd4;
        if (skip > 0) begin
            skip--; // Slot lost to a taken branch
        end else if (valid) begin
            exec_ref(ins, pc_i, wr, res, taken, target);
            if (wr) begin
                ret_due.push_back(cycle + 4); // Accepted at the next edge, retires 3 later
                ret_rd.push_back(ins[11:7]);
                ret_data.push_back(res);
            end
            if (taken) begin
                br_due.push_back(cycle + 2);
                br_target.push_back(target);
                skip = 2;
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        drive_slot(1'b0, 32'h0);
        while (ret_due.size() + br_due.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > 20) begin
                $display("Timed out after %0d cycles waiting for expected results", waited);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        $display("%-10s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // ----------------------------------------------------------------------
    // Comparison
    // ----------------------------------------------------------------------
    task automatic check_retire(input int due, input logic [REG_ADDR_W-1:0] exp_rd,
                                input logic [XLEN-1:0] exp_data);
        checks++;
        if (cycle != due) begin
            errors++;
            $display("ERROR at %0t: x%0d retired in cycle %0d, expected in cycle %0d",
                     $time, exp_rd, cycle, due);
        end
        if (retire_rd_o !== exp_rd || retire_data_o !== exp_data) begin
            errors++;
            $display("ERROR at %0t: retired x%0d = %h, expected x%0d = %h",
                     $time, retire_rd_o, retire_data_o, exp_rd, exp_data);
        end
    endtask

    task automatic check_branch(input int due, input logic [XLEN-1:0] exp_target);
        checks++;
        if (cycle != due || branch_target_o !== exp_target) begin
            errors++;
            $display("ERROR at %0t: branch to %h in cycle %0d, expected %h in cycle %0d",
                     $time, branch_target_o, cycle, exp_target, due);
        end
    endtask

    always @(negedge clk_i) begin
        if (reset_i) begin
            checks++;
            if (retire_valid_o !== 1'b0 || branch_taken_o !== 1'b0) begin
                errors++;
                $display("ERROR at %0t: retirement or taken branch while reset is active",
                         $time);
            end
        end else if (retire_valid_o) begin
            if (ret_due.size() == 0) begin
                errors++;
                $display("ERROR at %0t: unexpected retirement of x%0d", $time, retire_rd_o);
            end else begin
                check_retire(ret_due.pop_front(), ret_rd.pop_front(), ret_data.pop_front());
            end
        end else if (ret_due.size() != 0 && ret_due[0] <= cycle) begin
            errors++;
            $display("Retirement of x%0d due in cycle %0d never appeared", ret_rd[0], ret_due[0]);
            void'(ret_due.pop_front());
            void'(ret_rd.pop_front());
            void'(ret_data.pop_front());
        end
        if (!reset_i && branch_taken_o) begin
            if (br_due.size() == 0) begin
                errors++;
                $display("ERROR at %0t: unexpected taken branch to %h", $time, branch_target_o);
            end else begin
                check_branch(br_due.pop_front(), br_target.pop_front());
            end
        end else if (br_due.size() != 0 && br_due[0] <= cycle) begin
            errors++;
            $display("Taken branch due in cycle %0d never appeared", br_due[0]);
            void'(br_due.pop_front());
            void'(br_target.pop_front());
        end
    end

    initial begin
        logic [31:0] r;
        logic [11:0] imm;
        clk_i = 1'b0;
        reset_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = 32'h0;
        pc_i = '0;
        {cycle, errors, checks, mark_checks, mark_errors, skip} = '0;
        seed = 32'h1d0d4066;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        end_test("reset");

        drive_slot(1'b1, enc_imm(3'b000, -12'sd5, 5'd1, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd3, 5'd2, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd31, 5'd5, 5'd0));
        for (int f = 0; f < 8; f++) begin
            drive_slot(1'b1, enc_op(f, 1'b0, 5'd3, 5'd1, 5'd2));
            drive_slot(1'b1, enc_op(f, 1'b0, 5'd4, 5'd1, 5'd5)); // Shift by 31
            drive_slot(1'b1, enc_op(f, 1'b0, 5'd6, 5'd1, 5'd0)); // Shift by 0
            drive_slot(1'b1, enc_imm(f, (f == 1 || f == 5) ? 12'd31 : -12'sd7, 5'd7, 5'd1));
            drive_slot(1'b1, enc_imm(f, 12'd0, 5'd7, 5'd2));
        end
        drive_slot(1'b1, enc_op(3'b000, 1'b1, 5'd3, 5'd1, 5'd2));
        drive_slot(1'b1, enc_op(3'b101, 1'b1, 5'd3, 5'd1, 5'd5));
        drive_slot(1'b1, enc_imm(3'b101, 12'h41f, 5'd4, 5'd1));
        drive_slot(1'b1, enc_imm(3'b101, 12'h400, 5'd4, 5'd1));
        end_test("alu_ops");

        drive_slot(1'b1, enc_imm(3'b000, 12'd100, 5'd1, 5'd0));
        drive_slot(1'b1, enc_op(3'b000, 1'b0, 5'd2, 5'd1, 5'd1)); // Distance 1
        drive_slot(1'b1, enc_imm(3'b100, 12'd5, 5'd3, 5'd1));     // Distance 2
        drive_slot(1'b1, enc_op(3'b000, 1'b1, 5'd4, 5'd2, 5'd1)); // Distance 3 and 2
        drive_slot(1'b1, enc_op(3'b110, 1'b0, 5'd6, 5'd3, 5'd4));
        drive_slot(1'b1, enc_imm(3'b000, 12'd1, 5'd5, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd2, 5'd5, 5'd0));
        drive_slot(1'b1, enc_op(3'b000, 1'b0, 5'd6, 5'd5, 5'd5)); // Youngest producer wins
        end_test("forwarding");

        drive_slot(1'b1, enc_imm(3'b000, 12'd123, 5'd0, 5'd1));
        drive_slot(1'b1, enc_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2));
        drive_slot(1'b1, enc_op(3'b110, 1'b0, 5'd3, 5'd0, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd0, 5'd4, 5'd0));
        end_test("x0");

        drive_slot(1'b1, enc_imm(3'b000, 12'd9, 5'd1, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd9, 5'd2, 5'd0));
        drive_slot(1'b1, enc_br(1'b0, 13'd16, 5'd1, 5'd2)); // BEQ taken
        drive_slot(1'b1, enc_imm(3'b000, 12'd1, 5'd3, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd2, 5'd3, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd3, 5'd4, 5'd0));
        drive_slot(1'b1, enc_br(1'b1, -13'sd8, 5'd1, 5'd2)); // BNE not taken
        drive_slot(1'b1, enc_imm(3'b000, 12'd4, 5'd5, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd5, 5'd6, 5'd0));
        drive_slot(1'b1, enc_br(1'b1, -13'sd12, 5'd4, 5'd1)); // BNE taken
        drive_slot(1'b1, enc_br(1'b0, 13'd20, 5'd0, 5'd0));
        drive_slot(1'b1, enc_imm(3'b000, 12'd6, 5'd7, 5'd0));
        drive_slot(1'b1, enc_br(1'b0, 13'd20, 5'd1, 5'd3));  // BEQ not taken
        drive_slot(1'b1, enc_imm(3'b000, 12'd7, 5'd7, 5'd0));
        end_test("branches");

        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            if (r[31:29] == 3'd0) begin
                drive_slot(1'b0, 32'h0);
            end else if (r[14:12] < 3'd4) begin
                drive_slot(1'b1, enc_op(r[11:9], r[15] && (r[11:9] == 3'b000 ||
                                 r[11:9] == 3'b101), r[2:0], r[5:3], r[8:6]));
            end else if (r[14:12] < 3'd7) begin
                imm = r[27:16];
                if (r[11:9] == 3'b001 || r[11:9] == 3'b101) begin
                    imm = {1'b0, r[15] && r[11:9] == 3'b101, 5'b0, r[20:16]};
                end
                drive_slot(1'b1, enc_imm(r[11:9], imm, r[2:0], r[5:3]));
            end else begin
                drive_slot(1'b1, enc_br(r[9], {r[27:16], 1'b0}, r[5:3], r[8:6]));
            end
        end
        end_test("random");

        repeat (4) drive_slot(1'b0, 32'h0);
        $display("Total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_alu_core.u_hazard_unit_properties.fail_count);
        if (errors == 0 && u_alu_core.u_hazard_unit_properties.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
design/rv_isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/alu.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/retire_stages.sv
design/hazard_unit.sv
design/alu_core.sv
testbench/hazard_unit_properties.sv
testbench/alu_core_tb.sv
